/* Makefile */
SRCS := $(shell grep -v '^+' project.f) common/crop_macros.svh dv/tb_tasks.svh

.PHONY: run clean

run: obj_dir/Vtb_video_crop
	./obj_dir/Vtb_video_crop | tee /dev/stderr | grep -x 'PASS: all tests'

obj_dir/Vtb_video_crop: project.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f project.f --top-module tb_video_crop \
		-o Vtb_video_crop

clean:
	rm -rf obj_dir

/* common/crop_macros.svh */
// widths, key codes, step sizes and blank margins of the crop unit, included by RTL and testbench
`ifndef CROP_MACROS_SVH
`define CROP_MACROS_SVH

// field widths
`define CROP_W              12
`define RES_W               2
`define FLG_W               7

// keyboard message type carrying a key code
`define KEY_MSG_TYPE        3

// key codes
`define KEY_CODE_BACKSPACE  8'h41
`define KEY_CODE_UP         8'h4c
`define KEY_CODE_DOWN       8'h4d
`define KEY_CODE_RIGHT      8'h4e
`define KEY_CODE_LEFT       8'h4f
`define KEY_CODE_ALT_L      8'h64
`define KEY_CODE_ALT_R      8'h65
`define KEY_CODE_ALT_L_UP   8'he4
`define KEY_CODE_ALT_R_UP   8'he5

// crop steps per key press
`define HBL_STEP            4
`define VBL_STEP            1

// forced blank margins and soft edge lead
`define FORCE_H_MARGIN      8
`define SOFT_H_LEAD         2
`define FORCE_V_TAIL        2

`endif

/* common/crop_pkg.sv */
// shared struct and enum types of the crop unit, imported by every RTL block and the testbench
`include "crop_macros.svh"

package crop_pkg;

	// raw video timing from the core, syncs active low
	typedef struct packed {
		logic hs_n;
		logic vs_n;
		logic hblank;
		logic vblank;
		logic field1;
		logic lace;
	} sync_t;

	// crop edges, vbl_b with top bit set counts back from the last line
	typedef struct packed {
		logic [`CROP_W-1:0] hbl_l;
		logic [`CROP_W-1:0] hbl_r;
		logic [`CROP_W-1:0] vbl_t;
		logic [`CROP_W-1:0] vbl_b;
	} crop_t;

	// measured line and frame positions
	typedef struct packed {
		logic [`CROP_W-1:0] hcnt;
		logic [`CROP_W-1:0] hend;   // end of hblank
		logic [`CROP_W-1:0] hsta;   // start of hblank
		logic [`CROP_W-1:0] hmax;   // line length
		logic [`CROP_W-1:0] vcnt;
		logic [`CROP_W-1:0] vend;   // end of vblank
		logic [`CROP_W-1:0] vmax;   // frame length
		logic [`CROP_W-1:0] vs_end; // end of vsync
	} geom_t;

	typedef struct packed {
		logic [`CROP_W-1:0] hsize;
		logic [`CROP_W-1:0] vsize;
	} size_t;

	// new message on every toggle of level
	typedef struct packed {
		logic [7:0] code;
		logic [1:0] msg_type;
		logic       level;
	} key_msg_t;

	typedef enum logic [7:0] {
		KEY_BACKSPACE = `KEY_CODE_BACKSPACE,
		KEY_UP        = `KEY_CODE_UP,
		KEY_DOWN      = `KEY_CODE_DOWN,
		KEY_RIGHT     = `KEY_CODE_RIGHT,
		KEY_LEFT      = `KEY_CODE_LEFT,
		KEY_ALT_L     = `KEY_CODE_ALT_L,
		KEY_ALT_R     = `KEY_CODE_ALT_R,
		KEY_ALT_L_UP  = `KEY_CODE_ALT_L_UP,
		KEY_ALT_R_UP  = `KEY_CODE_ALT_R_UP
	} key_code_e;

	// screen info latched at end of vblank
	typedef struct packed {
		crop_t             crop;
		size_t             size;
		logic [`RES_W-1:0] res;
		logic [`FLG_W-1:0] flg;  // mode change counter
	} screen_info_t;

endpackage

/* crop/blank_gen.sv */
// builds soft and forced blanks from measured geometry and crop edges, drives registered de
`timescale 1ns/1ps
`include "crop_macros.svh"

module blank_gen (
	input  logic            clk_sys,
	input  logic            reset,
	input  crop_pkg::sync_t vin,
	input  crop_pkg::geom_t geom,
	input  crop_pkg::crop_t crop,
	output logic            de
);

	logic [`CROP_W-1:0] shbl_clr;
	logic [`CROP_W-1:0] shbl_set;
	logic [`CROP_W-1:0] fhbl_set;
	logic [`CROP_W-1:0] svbl_clr;
	logic [`CROP_W-1:0] svbl_set;
	logic [`CROP_W-1:0] fvbl_set;
	logic [`CROP_W-1:0] fvbl_clr;
	logic               shbl;
	logic               fhbl;
	logic               svbl;
	logic               fvbl;
	logic               hbl;
	logic               hbl_q;
	logic               vbl_eff;
	logic               v_update;

	// edge positions
	assign shbl_clr = geom.hend + crop.hbl_l - `CROP_W'(`SOFT_H_LEAD);
	assign shbl_set = geom.hsta + crop.hbl_r - `CROP_W'(`SOFT_H_LEAD);
	assign fhbl_set = geom.hmax - `CROP_W'(`FORCE_H_MARGIN);
	assign svbl_clr = geom.vend + crop.vbl_t;
	assign svbl_set = crop.vbl_b[`CROP_W-1] ? geom.vmax + crop.vbl_b : crop.vbl_b;
	assign fvbl_set = geom.vmax - `CROP_W'(1);
	assign fvbl_clr = geom.vs_end + `CROP_W'(`FORCE_V_TAIL);

	assign hbl      = fhbl | shbl | ~vin.hs_n;
	assign vbl_eff  = vin.vblank | ~vin.vs_n;
	assign v_update = (hbl_q & ~hbl) | (geom.vcnt == '0); // line start or line 0

	// horizontal blanks
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			shbl <= 1'b1;
			fhbl <= 1'b1;
		end else begin
			if (geom.hcnt == shbl_clr)
				shbl <= 1'b0;
			if (geom.hcnt == shbl_set)
				shbl <= 1'b1;
			if (geom.hcnt == `CROP_W'(`FORCE_H_MARGIN))
				fhbl <= 1'b0;
			if (geom.hcnt == fhbl_set)
				fhbl <= 1'b1;
		end
	end

	// vertical blanks and display enable
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			svbl  <= 1'b1;
			fvbl  <= 1'b1;
			hbl_q <= 1'b1;
			de    <= 1'b0;
		end else begin
			hbl_q <= hbl;
			if (v_update) begin
				if (geom.vcnt == svbl_clr)
					svbl <= 1'b0;
				if (geom.vcnt == svbl_set)
					svbl <= 1'b1;
				if (geom.vcnt == fvbl_set)
					fvbl <= 1'b1;
				if (geom.vcnt == fvbl_clr)
					fvbl <= 1'b0;
			end
			de <= ~hbl & ~svbl & ~fvbl & ~vbl_eff;
		end
	end

endmodule

/* crop/crop_keys.sv */
// holds the four crop edges, stepped by keyboard arrow messages or loaded by a host strobe
`timescale 1ns/1ps
`include "crop_macros.svh"

module crop_keys (
	input  logic               clk_sys,
	input  logic               reset,
	input  crop_pkg::key_msg_t key,
	input  logic               host_set,
	input  crop_pkg::crop_t    host_crop,
	output crop_pkg::crop_t    crop
);
	import crop_pkg::*;

	localparam logic [`CROP_W-1:0] H_STEP = `CROP_W'(`HBL_STEP);
	localparam logic [`CROP_W-1:0] V_STEP = `CROP_W'(`VBL_STEP);

	logic level_q;
	logic alt;      // alt held, selects far edge
	logic key_new;

	assign key_new = (level_q ^ key.level) && (key.msg_type == 2'(`KEY_MSG_TYPE));

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			level_q <= 1'b0;
			alt     <= 1'b0;
			crop    <= '0;
		end else begin
			level_q <= key.level;
			if (key_new) begin
				case (key.code)
					KEY_BACKSPACE: begin
						crop <= '0;
					end
					KEY_UP: begin
						if (alt)
							crop.vbl_b <= crop.vbl_b + V_STEP;
						else
							crop.vbl_t <= crop.vbl_t + V_STEP;
					end
					KEY_DOWN: begin
						if (alt)
							crop.vbl_b <= crop.vbl_b - V_STEP;
						else
							crop.vbl_t <= crop.vbl_t - V_STEP;
					end
					KEY_LEFT: begin
						if (alt)
							crop.hbl_r <= crop.hbl_r + H_STEP;
						else
							crop.hbl_l <= crop.hbl_l + H_STEP;
					end
					KEY_RIGHT: begin
						if (alt)
							crop.hbl_r <= crop.hbl_r - H_STEP;
						else
							crop.hbl_l <= crop.hbl_l - H_STEP;
					end
					KEY_ALT_L, KEY_ALT_R: begin
						alt <= 1'b1;
					end
					KEY_ALT_L_UP, KEY_ALT_R_UP: begin
						alt <= 1'b0;
					end
					default: begin
					end
				endcase
			end
			if (host_set)
				crop <= host_crop; // host load overrides a key in the same cycle
		end
	end

endmodule

/* crop/sync_measure.sv */
// measures line and frame geometry and the active size from the core syncs, interlace aware
`timescale 1ns/1ps
`include "crop_macros.svh"

module sync_measure (
	input  logic            clk_sys,
	input  logic            reset,
	input  crop_pkg::sync_t vin,
	output crop_pkg::geom_t geom,
	output crop_pkg::size_t size
);

	logic [`CROP_W-1:0] hcnt;
	logic [`CROP_W-1:0] hend;
	logic [`CROP_W-1:0] hsta;
	logic [`CROP_W-1:0] hmax;
	logic [`CROP_W-1:0] hsize;
	logic [`CROP_W-1:0] vcnt;
	logic [`CROP_W-1:0] vend;
	logic [`CROP_W-1:0] vmax;
	logic [`CROP_W-1:0] vs_end;
	logic [`CROP_W-1:0] vsize;
	logic [`CROP_W-1:0] f1_vend;
	logic [`CROP_W-1:0] f1_vsize;
	logic               phase;    // pixel counter runs at half rate
	logic               hs_q;
	logic               vs_q;
	logic               hbl_q;
	logic               vbl_q;
	logic               vbl_eff;

	assign vbl_eff = vin.vblank | ~vin.vs_n;

	// horizontal measurement
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			hcnt  <= '0;
			phase <= 1'b0;
			hend  <= '0;
			hsta  <= '0;
			hmax  <= '0;
			hsize <= '0;
			hs_q  <= 1'b1;
			hbl_q <= 1'b0;
		end else begin
			hs_q  <= vin.hs_n;
			hbl_q <= vin.hblank;
			if (~vin.hs_n) begin
				hcnt  <= '0; // held during hsync
				phase <= 1'b0;
			end else begin
				phase <= ~phase;
				if (phase)
					hcnt <= hcnt + 1'b1;
			end
			if (hbl_q & ~vin.hblank)
				hend <= hcnt;
			if (~hbl_q & vin.hblank)
				hsta <= hcnt;
			if (hs_q & ~vin.hs_n)
				hmax <= hcnt;
			// active width on line 1 of field 0
			if (~hbl_q & vin.hblank & ~vin.field1 & (vcnt == `CROP_W'(1)))
				hsize <= hcnt - hend;
		end
	end

	// vertical measurement
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			vcnt     <= '0;
			vend     <= '0;
			vmax     <= '0;
			vs_end   <= '0;
			vsize    <= '0;
			f1_vend  <= '0;
			f1_vsize <= '0;
			vs_q     <= 1'b1;
			vbl_q    <= 1'b0;
		end else begin
			vs_q  <= vin.vs_n;
			vbl_q <= vbl_eff;
			if (hs_q & ~vin.hs_n)
				vcnt <= vcnt + 1'b1;
			if (~vbl_q & vbl_eff)
				vcnt <= '0; // frame restarts at vblank
			if (~vin.lace | ~vin.field1) begin
				if (vbl_q & ~vbl_eff)
					vend <= vcnt;
				if (~vs_q & vin.vs_n)
					vs_end <= vcnt;
				if (~vbl_q & vbl_eff) begin
					vmax     <= vcnt;
					vsize    <= vcnt - vend + f1_vsize; // adds the field 1 lines
					f1_vsize <= '0;
				end
			end else begin
				if (vbl_q & ~vbl_eff)
					f1_vend <= vcnt;
				if (~vbl_q & vbl_eff)
					f1_vsize <= vcnt - f1_vend;
			end
		end
	end

	assign geom = '{hcnt, hend, hsta, hmax, vcnt, vend, vmax, vs_end};
	assign size = '{hsize, vsize};

endmodule

/* dv/tb_tasks.svh */
// directed tests, compare tasks and the frame wait that the crop testbench top includes
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check_crop(input string name, input crop_t exp, input crop_t act);
	n_checks++;
	if (act !== exp) begin
		error_count++;
		$display("FAILED %s: expected %h, actual %h", name, exp, act);
	end
endtask

task automatic check_size(input string name, input size_t exp, input size_t act);
	n_checks++;
	if (act !== exp) begin
		error_count++;
		$display("FAILED %s: expected %h, actual %h", name, exp, act);
	end
endtask

task automatic check_flg(input string name, input logic [`FLG_W-1:0] exp,
		input logic [`FLG_W-1:0] act);
	n_checks++;
	if (act !== exp) begin
		error_count++;
		$display("FAILED %s: expected %0d, actual %0d", name, exp, act);
	end
endtask

task automatic check_count(input string name, input int exp, input int act);
	n_checks++;
	if (act != exp) begin
		error_count++;
		$display("FAILED %s: expected %0d, actual %0d", name, exp, act);
	end
endtask

// hands a frame to the generator and waits for it
task automatic run_frame(input logic field1, input logic lace);
	int waited;
	waited     = 0;
	gen_field1 = field1;
	gen_lace   = lace;
	frame_req++;
	while (frame_done != frame_req) begin
		@(posedge clk_sys);
		waited++;
		if (waited > FRAME_TIMEOUT) begin
			error_count++;
			$display("ERROR: the frame generator did not finish a frame in time");
			$display("checks: %0d, errors: %0d", n_checks, error_count);
			$display("FAIL: see errors above");
			$finish;
		end
	end
	@(negedge clk_sys);
endtask

task automatic send_key(input logic [7:0] code, input logic [1:0] msg_type);
	@(posedge clk_sys);
	key <= '{code: code, msg_type: msg_type, level: ~key.level};
	repeat (2) @(posedge clk_sys); // edge moves on second edge after toggle
endtask

task automatic test_reset_state();
	@(negedge clk_sys);
	check_crop("reset_crop", '0, info.crop);
	check_size("reset_size", '0, info.size);
	check_flg("reset_flg", '0, info.flg);
	check_count("reset_res", 0, int'(info.res));
	check_count("reset_de", 0, int'(de));
endtask

task automatic test_size();
	size_t exp;
	exp.hsize = `CROP_W'(gen_hact);
	exp.vsize = `CROP_W'(VACT);
	run_frame(1'b0, 1'b0);
	run_frame(1'b0, 1'b0);
	check_size("progressive_size", exp, info.size);
endtask

task automatic test_interlace();
	size_t exp;
	exp.hsize = `CROP_W'(gen_hact);
	exp.vsize = `CROP_W'(2 * VACT); // both fields together
	run_frame(1'b1, 1'b1);
	run_frame(1'b0, 1'b1);
	run_frame(1'b1, 1'b1);
	check_size("interlace_sum", exp, info.size);
endtask

task automatic test_keys();
	crop_t exp;
	exp = '0;
	send_key(KEY_UP, 2'(`KEY_MSG_TYPE));
	exp.vbl_t = exp.vbl_t + `CROP_W'(`VBL_STEP);
	run_frame(1'b0, 1'b0);
	check_crop("key_up", exp, info.crop);
	send_key(KEY_ALT_L, 2'(`KEY_MSG_TYPE));
	send_key(KEY_UP, 2'(`KEY_MSG_TYPE));
	exp.vbl_b = exp.vbl_b + `CROP_W'(`VBL_STEP);
	run_frame(1'b0, 1'b0);
	check_crop("key_alt_up", exp, info.crop);
	send_key(KEY_ALT_L_UP, 2'(`KEY_MSG_TYPE));
	send_key(KEY_LEFT, 2'(`KEY_MSG_TYPE));
	exp.hbl_l = exp.hbl_l + `CROP_W'(`HBL_STEP);
	run_frame(1'b0, 1'b0);
	check_crop("key_left", exp, info.crop);
	send_key(KEY_ALT_R, 2'(`KEY_MSG_TYPE));
	send_key(KEY_RIGHT, 2'(`KEY_MSG_TYPE));
	exp.hbl_r = exp.hbl_r - `CROP_W'(`HBL_STEP);
	run_frame(1'b0, 1'b0);
	check_crop("key_alt_right", exp, info.crop);
	send_key(KEY_ALT_R_UP, 2'(`KEY_MSG_TYPE));
	send_key(KEY_DOWN, 2'd0); // other message type is ignored
	run_frame(1'b0, 1'b0);
	check_crop("key_wrong_type", exp, info.crop);
	send_key(KEY_BACKSPACE, 2'(`KEY_MSG_TYPE));
	run_frame(1'b0, 1'b0);
	check_crop("key_backspace", '0, info.crop);
endtask

task automatic test_host_de();
	crop_t c;
	int    first_line;
	int    exp_lines;
	int    de_lines;
	c       = '0;
	c.hbl_l = `CROP_W'($urandom % 8);
	c.hbl_r = `CROP_W'($urandom % 8);
	c.vbl_t = `CROP_W'($urandom % 4);
	@(posedge clk_sys);
	host_set  <= 1'b1;
	host_crop <= c;
	@(posedge clk_sys);
	host_set <= 1'b0;
	run_frame(1'b0, 1'b0);
	check_crop("host_load", c, info.crop);
	// soft edges move left edge in and right edge out at two clocks per pixel
	check_count("de_mid_line", 2 * (gen_hact + int'(c.hbl_r) - int'(c.hbl_l)),
		de_cnt[MID_LINE]);
	first_line = (VBL - 1) + int'(c.vbl_t); // vend plus vbl_t
	if (first_line < VBL)
		first_line = VBL;
	exp_lines = (VBL + VACT - 2) - first_line + 1; // forced blank from vmax minus 1
	de_lines  = 0;
	for (int i = 0; i < FRAME_LINES; i++) begin
		if (de_cnt[i] > 0)
			de_lines++;
	end
	check_count("de_lines", exp_lines, de_lines);
endtask

task automatic test_mode_flag();
	logic [`FLG_W-1:0] flg0;
	size_t             exp;
	run_frame(1'b0, 1'b0);
	flg0 = info.flg;
	run_frame(1'b0, 1'b0);
	check_flg("flg_same_frame", flg0, info.flg);
	@(posedge clk_sys);
	res <= 2'd1;
	run_frame(1'b0, 1'b0);
	check_flg("flg_res_change", flg0 + `FLG_W'(1), info.flg);
	check_count("res_latched", 1, int'(info.res));
	run_frame(1'b0, 1'b0);
	check_flg("flg_res_steady", flg0 + `FLG_W'(1), info.flg);
	gen_hact  = 48;
	exp.hsize = `CROP_W'(48);
	exp.vsize = `CROP_W'(VACT);
	run_frame(1'b0, 1'b0);
	check_flg("flg_width_change", flg0 + `FLG_W'(2), info.flg);
	check_size("width_size", exp, info.size);
	run_frame(1'b0, 1'b0);
	check_flg("flg_width_steady", flg0 + `FLG_W'(2), info.flg);
endtask

`endif

/* dv/tb_video_crop.sv */
// testbench top for the video crop unit, drives frames and keys and runs the directed tests
`timescale 1ns/1ps
`include "crop_macros.svh"

module tb_video_crop;
	import crop_pkg::*;

	localparam int HS            = 8;     // hsync pixels
	localparam int HBP           = 16;    // back porch pixels
	localparam int HFP           = 16;    // front porch pixels
	localparam int VBL           = 6;     // blank lines at frame start
	localparam int VACT          = 20;    // active lines
	localparam int FRAME_LINES   = VBL + VACT;
	localparam int MID_LINE      = 15;
	localparam int FRAME_TIMEOUT = 20000; // cycles per frame

	logic         clk_sys;
	logic         reset;
	sync_t        vin;
	logic [1:0]   res;
	key_msg_t     key;
	logic         host_set;
	crop_t        host_crop;
	logic         de;
	screen_info_t info;

	int   error_count = 0;
	int   n_checks = 0;
	int   frame_req = 0;
	int   frame_done = 0;
	int   gen_hact = 64;      // active pixels per line
	logic gen_field1 = 1'b0;
	logic gen_lace = 1'b0;
	int   de_cnt [FRAME_LINES]; // de-high cycles per line of the last frame

	video_crop u_dut (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.vin       (vin),
		.res       (res),
		.key       (key),
		.host_set  (host_set),
		.host_crop (host_crop),
		.de        (de),
		.info      (info)
	);

	`include "tb_tasks.svh"

	// one frame, each pixel held for two clocks
	task automatic drive_frame();
		sync_t v;
		int    line_len;
		line_len = HS + HBP + gen_hact + HFP;
		for (int line = 0; line < FRAME_LINES; line++) begin
			de_cnt[line] = 0;
			for (int p = 0; p < line_len; p++) begin
				for (int half = 0; half < 2; half++) begin
					v        = vin;
					v.hs_n   = (p >= HS);
					v.hblank = !(p >= HS + HBP && p < HS + HBP + gen_hact);
					v.vblank = (line < VBL);
					v.vs_n   = !(line == 1 || line == 2);
					if (line != 0) begin // field flags change one line into the frame
						v.field1 = gen_field1;
						v.lace   = gen_lace;
					end
					@(posedge clk_sys);
					vin <= v;
					@(negedge clk_sys);
					if (de)
						de_cnt[line]++;
				end
			end
		end
	endtask

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// frame generator, serves one request at a time
	initial begin
		forever begin
			@(posedge clk_sys);
			if (frame_done != frame_req) begin
				drive_frame();
				frame_done++;
			end
		end
	end

	initial begin
		int seed;
		seed      = $urandom(32'h247b6385);
		reset     = 1'b1;
		vin       = '{hs_n: 1'b1, vs_n: 1'b1, hblank: 1'b1, vblank: 1'b1,
		              field1: 1'b0, lace: 1'b0};
		res       = '0;
		key       = '0;
		host_set  = 1'b0;
		host_crop = '0;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
		test_reset_state();
		test_size();
		test_interlace();
		test_keys();
		test_host_de();
		test_mode_flag();
		$display("checks: %0d, errors: %0d", n_checks, error_count);
		if (error_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* project.f */
+incdir+common
+incdir+dv
common/crop_pkg.sv
crop/sync_measure.sv
crop/crop_keys.sv
crop/blank_gen.sv
src/mode_snapshot.sv
src/video_crop.sv
dv/tb_video_crop.sv

/* src/mode_snapshot.sv */
// latches crop, active size and resolution at the end of vblank and counts mode changes
`timescale 1ns/1ps

module mode_snapshot (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  crop_pkg::sync_t        vin,
	input  crop_pkg::crop_t        crop,
	input  crop_pkg::size_t        size,
	input  logic [1:0]             res,
	output crop_pkg::screen_info_t info
);

	logic vbl_eff;
	logic vbl_q;
	logic changed;

	assign vbl_eff = vin.vblank | ~vin.vs_n;

	// compared against the snapshot about to be replaced
	assign changed = (info.res != res) || (info.size != size);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			vbl_q <= 1'b0;
			info  <= '0;
		end else begin
			vbl_q <= vbl_eff;
			if (vbl_q & ~vbl_eff) begin // end of vblank
				info.crop <= crop;
				info.size <= size;
				info.res  <= res;
				if (changed)
					info.flg <= info.flg + 1'b1;
			end
		end
	end

endmodule

/* src/video_crop.sv */
// top level of the video crop unit, connects measurement, crop keys, blank generation and snapshot
`timescale 1ns/1ps

module video_crop (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  crop_pkg::sync_t        vin,
	input  logic [1:0]             res,
	input  crop_pkg::key_msg_t     key,
	input  logic                   host_set,
	input  crop_pkg::crop_t        host_crop,
	output logic                   de,
	output crop_pkg::screen_info_t info
);
	import crop_pkg::*;

	geom_t geom;
	size_t size;
	crop_t crop;

	sync_measure u_sync_measure (
		.clk_sys (clk_sys),
		.reset   (reset),
		.vin     (vin),
		.geom    (geom),
		.size    (size)
	);

	crop_keys u_crop_keys (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.key       (key),
		.host_set  (host_set),
		.host_crop (host_crop),
		.crop      (crop)
	);

	blank_gen u_blank_gen (
		.clk_sys (clk_sys),
		.reset   (reset),
		.vin     (vin),
		.geom    (geom),
		.crop    (crop),
		.de      (de)
	);

	mode_snapshot u_mode_snapshot (
		.clk_sys (clk_sys),
		.reset   (reset),
		.vin     (vin),
		.crop    (crop),
		.size    (size),
		.res     (res),
		.info    (info)
	);

endmodule
